// ==== src/icache_pkg.sv ====
package icache_pkg;

  // --------------------------------------------------------------------------
  // Geometry
  // --------------------------------------------------------------------------
  localparam int NUM_SETS   = 16;  // Sets in the cache
  localparam int NUM_WAYS   = 8;   // Ways per set
  localparam int LINE_WORDS = 4;   // Words per line, also beats per burst
  localparam int BURST_LEN  = 3;   // Beats minus one, AXI len encoding

  // Address field positions, byte address
  localparam int WORD_LSB  = 2;    // Two byte bits below are ignored
  localparam int INDEX_LSB = 4;
  localparam int TAG_LSB   = 8;

  // --------------------------------------------------------------------------
  // Width types
  // --------------------------------------------------------------------------
  typedef logic [31:0]  addr_t;      // Byte address
  typedef logic [31:0]  word_t;      // Fetch word
  typedef logic [127:0] line_t;      // One cache line
  typedef logic [23:0]  tag_t;
  typedef logic [3:0]   index_t;     // Set index
  typedef logic [1:0]   word_sel_t;  // Word within line
  typedef logic [2:0]   way_t;
  typedef logic [7:0]   way_mask_t;  // One bit per way

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    HIT_RESP,
    REFILL,
    FILL,
    MISS_RESP
  } cache_state_e;

  // --------------------------------------------------------------------------
  // Block-to-block bundles
  // --------------------------------------------------------------------------
  typedef struct packed {
    index_t index;
    tag_t   tag;
  } lookup_req_t;

  typedef struct packed {
    logic      hit;
    way_t      way;         // Lowest hitting way
    line_t     line;        // Line held in that way
    way_mask_t valid_mask;  // Valid bits of the addressed set
  } lookup_rsp_t;

  typedef struct packed {
    index_t index;
    tag_t   tag;
    way_t   way;
    line_t  line;
  } fill_t;

  typedef struct packed {
    addr_t      addr;  // Line aligned
    logic [7:0] len;
  } mem_ar_t;

endpackage

// ==== src/icache_store.sv ====
module icache_store (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      flush_i,
  input  icache_pkg::lookup_req_t   lookup_i,
  output icache_pkg::lookup_rsp_t   lookup_o,
  input  logic                      fill_valid_i,
  input  icache_pkg::fill_t         fill_i
);

  import icache_pkg::*;

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------
  way_mask_t valid_q  [NUM_SETS];            // Per set valid bits
  tag_t      tag_mem  [NUM_SETS][NUM_WAYS];
  line_t     line_mem [NUM_SETS][NUM_WAYS];

  way_mask_t hit_vec;
  way_t      hit_way;

  // Parallel tag compare over the addressed set
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = valid_q[lookup_i.index][w] &&
                   (tag_mem[lookup_i.index][w] == lookup_i.tag);
    end
  end

  // Priority encode, lowest way wins
  always_comb begin
    hit_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign lookup_o.hit        = |hit_vec;
  assign lookup_o.way        = hit_way;
  assign lookup_o.line       = line_mem[lookup_i.index][hit_way];
  assign lookup_o.valid_mask = valid_q[lookup_i.index];

  // --------------------------------------------------------------------------
  // Valid bits, flush beats fill
  // --------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || flush_i) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (fill_valid_i) begin
      valid_q[fill_i.index][fill_i.way] <= 1'b1;
    end
  end

  // Tag and data arrays
  always_ff @(posedge clock) begin
    if (fill_valid_i && !flush_i) begin
      tag_mem[fill_i.index][fill_i.way]  <= fill_i.tag;
      line_mem[fill_i.index][fill_i.way] <= fill_i.line;
    end
  end

  // A fill only ever installs a tag absent from the set
  a_single_hit : assert property (
    @(posedge clock) disable iff (reset) $onehot0(hit_vec)
  );

endmodule

// ==== src/icache_victim.sv ====
module icache_victim (
  input  logic                    clock,
  input  logic                    reset,
  input  icache_pkg::way_mask_t   valid_mask_i,
  output icache_pkg::way_t        victim_o
);

  import icache_pkg::*;

  logic [7:0] lfsr_q;  // x^8 + x^6 + x^5 + x^4 + 1
  logic       lfsr_fb;
  way_t       free_way;

  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clock) begin
    if (reset) begin
      lfsr_q <= 8'h01;                    // Any nonzero seed
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};   // Steps every cycle
    end
  end

  // Lowest invalid way
  always_comb begin
    free_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_mask_i[w]) begin
        free_way = way_t'(w);
      end
    end
  end

  // Full set falls back to pseudo-random way
  assign victim_o = (&valid_mask_i) ? way_t'(lfsr_q[2:0]) : free_way;

  a_lfsr_nonzero : assert property (
    @(posedge clock) disable iff (reset) lfsr_q != '0
  );

endmodule

// ==== src/icache_refill.sv ====
module icache_refill (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  start_i,
  input  icache_pkg::addr_t     addr_i,
  output logic                  mem_arvalid_o,
  input  logic                  mem_arready_i,
  output icache_pkg::mem_ar_t   mem_ar_o,
  input  logic                  mem_rvalid_i,
  input  icache_pkg::word_t     mem_rdata_i,
  input  logic                  mem_rlast_i,
  output logic                  mem_rready_o,
  output logic                  done_o,
  output icache_pkg::line_t     line_o
);

  import icache_pkg::*;

  logic      arvalid_q;
  logic      rready_q;
  logic      done_q;
  mem_ar_t   ar_q;       // Held until accepted
  word_sel_t beat_cnt_q; // Next word slot
  line_t     line_q;
  logic      beat;

  assign beat = mem_rvalid_i && rready_q;

  // --------------------------------------------------------------------------
  // Burst control
  // --------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      arvalid_q  <= 1'b0;
      rready_q   <= 1'b0;
      done_q     <= 1'b0;
      beat_cnt_q <= '0;
    end else begin
      done_q <= 1'b0;                       // Single cycle pulse
      if (start_i) begin
        arvalid_q  <= 1'b1;
        beat_cnt_q <= '0;
      end else if (arvalid_q && mem_arready_i) begin
        arvalid_q <= 1'b0;
        rready_q  <= 1'b1;                  // Data phase opens
      end
      if (beat) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        if (mem_rlast_i) begin
          rready_q <= 1'b0;
          done_q   <= 1'b1;
        end
      end
    end
  end

  // Address and line payload
  always_ff @(posedge clock) begin
    if (start_i) begin
      ar_q.addr <= {addr_i[$bits(addr_t)-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
      ar_q.len  <= 8'(BURST_LEN);
    end
    if (beat) begin
      line_q[beat_cnt_q * $bits(word_t) +: $bits(word_t)] <= mem_rdata_i;  // Word 0 first
    end
  end

  assign mem_arvalid_o = arvalid_q;
  assign mem_ar_o      = ar_q;
  assign mem_rready_o  = rready_q;
  assign done_o        = done_q;
  assign line_o        = line_q;

  // Memory side must honour the burst length it was given
  a_last_beat : assert property (
    @(posedge clock) disable iff (reset)
    beat |-> (mem_rlast_i == (beat_cnt_q == word_sel_t'(LINE_WORDS - 1)))
  );

  a_no_overlap : assert property (
    @(posedge clock) disable iff (reset) start_i |-> !(arvalid_q || rready_q)
  );

endmodule

// ==== src/icache_ctrl.sv ====
module icache_ctrl (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      arvalid_i,
  input  icache_pkg::addr_t         araddr_i,
  output logic                      arready_o,
  output logic                      rvalid_o,
  output icache_pkg::word_t         rdata_o,
  input  logic                      rready_i,
  output icache_pkg::lookup_req_t   lookup_req_o,
  input  icache_pkg::lookup_rsp_t   lookup_rsp_i,
  input  icache_pkg::way_t          victim_i,
  output logic                      refill_start_o,
  output icache_pkg::addr_t         refill_addr_o,
  input  logic                      refill_done_i,
  input  icache_pkg::line_t         refill_line_i,
  output logic                      fill_valid_o,
  output icache_pkg::fill_t         fill_o,
  output logic                      lookup_o,
  output logic                      hit_o
);

  import icache_pkg::*;

  cache_state_e state_q, state_d;
  addr_t        addr_q;     // Accepted request
  line_t        rbuf_q;     // Response line buffer
  way_t         victim_q;
  word_sel_t    word_sel;
  index_t       index;
  tag_t         tag;

  assign word_sel = addr_q[WORD_LSB +: $bits(word_sel_t)];
  assign index    = addr_q[INDEX_LSB +: $bits(index_t)];
  assign tag      = addr_q[TAG_LSB +: $bits(tag_t)];

  // --------------------------------------------------------------------------
  // State machine
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (arvalid_i) state_d = LOOKUP;
      LOOKUP:    state_d = lookup_rsp_i.hit ? HIT_RESP : REFILL;
      HIT_RESP:  if (rready_i) state_d = IDLE;
      REFILL:    if (refill_done_i) state_d = FILL;
      FILL:      state_d = MISS_RESP;          // Line written this cycle
      MISS_RESP: if (rready_i) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address, victim and response line
  always_ff @(posedge clock) begin
    if (state_q == IDLE && arvalid_i) begin
      addr_q <= araddr_i;
    end
    if (state_q == LOOKUP) begin
      victim_q <= victim_i;                    // Chosen before any refill
      if (lookup_rsp_i.hit) begin
        rbuf_q <= lookup_rsp_i.line;
      end
    end
    if (state_q == REFILL && refill_done_i) begin
      rbuf_q <= refill_line_i;
    end
  end

  // --------------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------------
  assign arready_o = (state_q == IDLE);
  assign rvalid_o  = (state_q == HIT_RESP) || (state_q == MISS_RESP);
  assign rdata_o   = rbuf_q[word_sel * $bits(word_t) +: $bits(word_t)];

  assign lookup_req_o.index = index;
  assign lookup_req_o.tag   = tag;

  assign refill_start_o = (state_q == LOOKUP) && !lookup_rsp_i.hit;
  assign refill_addr_o  = addr_q;              // Aligned by refill master

  assign fill_valid_o = (state_q == FILL);
  assign fill_o.index = index;
  assign fill_o.tag   = tag;
  assign fill_o.way   = victim_q;
  assign fill_o.line  = rbuf_q;

  // Performance strobes
  assign lookup_o = (state_q == LOOKUP);
  assign hit_o    = (state_q == LOOKUP) && lookup_rsp_i.hit;

  // Core sees a stable word under back-pressure
  a_rdata_stable : assert property (
    @(posedge clock) disable iff (reset)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o)
  );

endmodule

// ==== src/icache_top.sv ====
module icache_top (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  flush_i,
  // Core fetch port
  input  logic                  arvalid_i,
  input  icache_pkg::addr_t     araddr_i,
  output logic                  arready_o,
  output logic                  rvalid_o,
  output icache_pkg::word_t     rdata_o,
  input  logic                  rready_i,
  // Memory burst port
  output logic                  mem_arvalid_o,
  input  logic                  mem_arready_i,
  output icache_pkg::mem_ar_t   mem_ar_o,
  input  logic                  mem_rvalid_i,
  input  icache_pkg::word_t     mem_rdata_i,
  input  logic                  mem_rlast_i,
  output logic                  mem_rready_o,
  // Performance strobes
  output logic                  lookup_o,
  output logic                  hit_o
);

  import icache_pkg::*;

  lookup_req_t lookup_req;
  lookup_rsp_t lookup_rsp;
  way_t        victim;
  logic        refill_start;
  addr_t       refill_addr;
  logic        refill_done;
  line_t       refill_line;
  logic        fill_valid;
  fill_t       fill;

  icache_ctrl i_ctrl (
    .clock          (clock),
    .reset          (reset),
    .arvalid_i      (arvalid_i),
    .araddr_i       (araddr_i),
    .arready_o      (arready_o),
    .rvalid_o       (rvalid_o),
    .rdata_o        (rdata_o),
    .rready_i       (rready_i),
    .lookup_req_o   (lookup_req),
    .lookup_rsp_i   (lookup_rsp),
    .victim_i       (victim),
    .refill_start_o (refill_start),
    .refill_addr_o  (refill_addr),
    .refill_done_i  (refill_done),
    .refill_line_i  (refill_line),
    .fill_valid_o   (fill_valid),
    .fill_o         (fill),
    .lookup_o       (lookup_o),
    .hit_o          (hit_o)
  );

  icache_store i_store (
    .clock        (clock),
    .reset        (reset),
    .flush_i      (flush_i),
    .lookup_i     (lookup_req),
    .lookup_o     (lookup_rsp),
    .fill_valid_i (fill_valid),
    .fill_i       (fill)
  );

  icache_victim i_victim (
    .clock        (clock),
    .reset        (reset),
    .valid_mask_i (lookup_rsp.valid_mask),
    .victim_o     (victim)
  );

  icache_refill i_refill (
    .clock         (clock),
    .reset         (reset),
    .start_i       (refill_start),
    .addr_i        (refill_addr),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_arready_i (mem_arready_i),
    .mem_ar_o      (mem_ar_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rlast_i   (mem_rlast_i),
    .mem_rready_o  (mem_rready_o),
    .done_o        (refill_done),
    .line_o        (refill_line)
  );

endmodule

// ==== bench/icache_mem_model.sv ====
module icache_mem_model (
  input  logic                clock,
  input  logic                reset,
  input  logic                ar_stall_i,       // Random back-pressure from the testbench
  input  logic                r_stall_i,
  input  logic                arvalid_i,
  output logic                arready_o,
  input  icache_pkg::mem_ar_t ar_i,
  output logic                rvalid_o,
  output icache_pkg::word_t   rdata_o,
  output logic                rlast_o,
  input  logic                rready_i,
  output int                  burst_cnt_o,      // Accepted bursts
  output int                  bad_burst_cnt_o   // Misaligned or wrong length
);

  timeunit 1ns;
  timeprecision 1ps;

  import icache_pkg::*;

  logic       busy_q;
  addr_t      base_q;   // Word address of beat 0
  logic [1:0] beat_q;

  // Memory content rule, by word address
  function automatic word_t word_value(input addr_t word_addr);
    return word_addr * 32'h9E3779B1 + 32'h1234;
  endfunction

  assign arready_o = !busy_q && !ar_stall_i;   // One burst at a time
  assign rvalid_o  = busy_q && !r_stall_i;
  assign rdata_o   = word_value(base_q + addr_t'(beat_q));
  assign rlast_o   = (beat_q == 2'(LINE_WORDS - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q          <= 1'b0;
      beat_q          <= '0;
      base_q          <= '0;
      burst_cnt_o     <= 0;
      bad_burst_cnt_o <= 0;
    end else begin
      if (arvalid_i && arready_o) begin
        busy_q      <= 1'b1;
        beat_q      <= '0;
        base_q      <= ar_i.addr >> WORD_LSB;
        burst_cnt_o <= burst_cnt_o + 1;
        if (ar_i.addr[INDEX_LSB-1:0] != '0 || ar_i.len != 8'(BURST_LEN)) begin
          bad_burst_cnt_o <= bad_burst_cnt_o + 1;
        end
      end
      if (rvalid_o && rready_i) begin
        beat_q <= beat_q + 1'b1;
        if (rlast_o) begin
          busy_q <= 1'b0;                    // Burst complete
        end
      end
    end
  end

endmodule

// ==== bench/icache_tb.sv ====
module icache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import icache_pkg::*;

  localparam int ACCESSES    = 608;                 // Sum over all tests below
  localparam int CYCLE_LIMIT = ACCESSES * 64 + 1000;

  logic    clock = 1'b0;
  logic    reset = 1'b1;
  logic    flush_i = 1'b0;
  logic    arvalid_i = 1'b0;
  addr_t   araddr_i = '0;
  logic    arready_o;
  logic    rvalid_o;
  word_t   rdata_o;
  logic    rready_i = 1'b0;
  logic    mem_arvalid, mem_arready, mem_rvalid, mem_rlast, mem_rready;
  mem_ar_t mem_ar;
  word_t   mem_rdata;
  logic    lookup_o, hit_o;
  logic    ar_stall = 1'b0;
  logic    r_stall = 1'b0;
  int      burst_cnt, bad_burst_cnt;

  int          cycles = 0;
  int          lookup_cnt = 0;
  int unsigned lcg_q = 11192;
  int          checks = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          bursts_exp = 0;
  int          lookups_exp = 0;
  addr_t       last_fill = '1;               // Line number of the latest miss
  tag_t        resident [NUM_SETS][$];       // Tags filled since last flush
  tag_t        saved    [NUM_SETS][$];

  always #10 clock = ~clock;

  icache_top i_dut (
    .clock (clock), .reset (reset), .flush_i (flush_i),
    .arvalid_i (arvalid_i), .araddr_i (araddr_i), .arready_o (arready_o),
    .rvalid_o (rvalid_o), .rdata_o (rdata_o), .rready_i (rready_i),
    .mem_arvalid_o (mem_arvalid), .mem_arready_i (mem_arready), .mem_ar_o (mem_ar),
    .mem_rvalid_i (mem_rvalid), .mem_rdata_i (mem_rdata), .mem_rlast_i (mem_rlast),
    .mem_rready_o (mem_rready), .lookup_o (lookup_o), .hit_o (hit_o)
  );

  icache_mem_model i_mem (
    .clock (clock), .reset (reset), .ar_stall_i (ar_stall), .r_stall_i (r_stall),
    .arvalid_i (mem_arvalid), .arready_o (mem_arready), .ar_i (mem_ar),
    .rvalid_o (mem_rvalid), .rdata_o (mem_rdata), .rlast_o (mem_rlast),
    .rready_i (mem_rready), .burst_cnt_o (burst_cnt), .bad_burst_cnt_o (bad_burst_cnt)
  );

  // Cycle limit and lookup strobe count
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (!reset && lookup_o) lookup_cnt <= lookup_cnt + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  function automatic int unsigned next_rand();
    lcg_q = lcg_q * 32'd1103515245 + 32'd12345;
    return lcg_q >> 16;                      // Upper bits, better period
  endfunction

  function automatic word_t expected_word(input addr_t word_addr);
    return word_addr * 32'h9E3779B1 + 32'h1234;
  endfunction

  function automatic addr_t make_addr(input tag_t tag, input index_t idx, input word_sel_t ws);
    return {tag, idx, ws, 2'b00};
  endfunction

  // Position of a tag in one set's list, or -1
  function automatic int find_tag(input index_t idx, input tag_t tag);
    for (int i = 0; i < resident[idx].size(); i++) begin
      if (resident[idx][i] == tag) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Next falling edge, new memory stalls
  task automatic step();
    int unsigned r;
    @(negedge clock);
    r = next_rand();
    ar_stall = r[0] & r[1];
    r_stall  = r[2];
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    check_count({name, " bad bursts"}, 0, bad_burst_cnt);
    tests_run++;
    if (errors == errors_before) begin
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s with %0d errors", name, errors - errors_before);
    end
  endtask

  // One fetch through the core port, checked against the model
  task automatic access(input string name, input addr_t addr);
    index_t idx;
    tag_t   tag;
    int     pos;
    int     t;
    int     t_valid;
    logic   exp_hit;
    logic   got_hit;
    bit     known;
    word_t  exp_word;
    idx      = addr[INDEX_LSB +: 4];
    tag      = addr[TAG_LSB +: 24];
    pos      = find_tag(idx, tag);
    exp_hit  = (pos >= 0);
    known    = !exp_hit || resident[idx].size() <= NUM_WAYS || (addr >> 4) == last_fill;
    exp_word = expected_word(addr >> WORD_LSB);
    step();
    arvalid_i = 1'b1;
    araddr_i  = addr;
    while (!arready_o) step();
    step();                                  // Accepted, now in LOOKUP
    arvalid_i = 1'b0;
    lookups_exp++;
    if (!lookup_o) begin
      errors++;
      $display("%s: no lookup strobe in the cycle after acceptance", name);
    end
    got_hit = hit_o;
    if (known) check_flag({name, " hit"}, exp_hit, got_hit);
    t       = 1;
    t_valid = 0;
    do begin
      step();
      t++;
      rready_i = (next_rand() % 4) != 0;     // Back-pressure about a quarter of cycles
      if (rvalid_o && t_valid == 0) t_valid = t;
    end while (!(rvalid_o && rready_i));
    check_word(name, exp_word, rdata_o);
    if (got_hit) check_count({name, " hit latency"}, 2, t_valid);
    step();
    rready_i = 1'b0;
    if (!got_hit) begin
      bursts_exp++;
      last_fill = addr >> 4;
      if (pos < 0) resident[idx].push_back(tag);
    end
    check_count({name, " bursts"}, bursts_exp, burst_cnt);
    check_count({name, " lookups"}, lookups_exp, lookup_cnt);
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin
    int   e0;
    tag_t tag;
    int   s;
    repeat (10) step();
    e0 = errors;
    check_flag("reset arready", 1'b1, arready_o);
    check_flag("reset rvalid", 1'b0, rvalid_o);
    check_flag("reset mem_arvalid", 1'b0, mem_arvalid);
    check_flag("reset mem_rready", 1'b0, mem_rready);
    check_flag("reset lookup", 1'b0, lookup_o);
    check_flag("reset hit", 1'b0, hit_o);
    reset = 1'b0;
    end_test("reset_state", e0);

    e0 = errors;                             // 8 distinct lines per set, all miss
    for (int i = 0; i < NUM_SETS; i++) begin
      for (int k = 0; k < NUM_WAYS; k++) begin
        tag = {16'(next_rand()), 8'(k)};
        access("cold_fill", make_addr(tag, index_t'(i), word_sel_t'(next_rand())));
      end
    end
    end_test("cold_fill", e0);

    e0 = errors;                             // Every filled line stays resident
    repeat (200) begin
      s   = next_rand() % NUM_SETS;
      tag = resident[s][next_rand() % resident[s].size()];
      access("resident_hits", make_addr(tag, index_t'(s), word_sel_t'(next_rand())));
    end
    end_test("resident_hits", e0);

    e0 = errors;
    step();
    flush_i = 1'b1;
    step();
    flush_i = 1'b0;
    for (int i = 0; i < NUM_SETS; i++) begin
      saved[i] = resident[i];
      resident[i].delete();
    end
    for (int i = 0; i < NUM_SETS; i++) begin
      tag = saved[i][next_rand() % saved[i].size()];
      access("flush", make_addr(tag, index_t'(i), word_sel_t'(next_rand())));
    end
    end_test("flush", e0);

    e0 = errors;                             // 13 lines into set 5
    for (int j = 0; j < 12; j++) begin
      tag = {16'hA500 + 16'(j), 8'hFF};
      access("set_overflow", make_addr(tag, 4'd5, word_sel_t'(next_rand())));
      access("set_overflow", make_addr(tag, 4'd5, word_sel_t'(next_rand())));
    end
    repeat (40) begin
      tag = resident[5][next_rand() % resident[5].size()];
      access("set_overflow", make_addr(tag, 4'd5, word_sel_t'(next_rand())));
    end
    end_test("set_overflow", e0);

    e0 = errors;
    repeat (200) begin
      tag = 24'h000100 + 24'(next_rand() % 6);
      s   = next_rand() % NUM_SETS;
      access("random_mix", make_addr(tag, index_t'(s), word_sel_t'(next_rand())));
    end
    end_test("random_mix", e0);

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
src/icache_pkg.sv
src/icache_store.sv
src/icache_victim.sv
src/icache_refill.sv
src/icache_ctrl.sv
src/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  # Package first, then leaf blocks, then the top level
  - files:
      - src/icache_pkg.sv
      - src/icache_store.sv
      - src/icache_victim.sv
      - src/icache_refill.sv
      - src/icache_ctrl.sv
      - src/icache_top.sv

  # Testbench, top module icache_tb
  - target: test
    files:
      - bench/icache_mem_model.sv
      - bench/icache_tb.sv
